// File: hw/soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam id_t ID_FETCH = 4'd1;
    localparam id_t ID_DATA  = 4'd2;

    // single-beat word transfers only
    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // mtime inside the clint window
    localparam logic [15:0] MTIME_LO_OFFSET = 16'hbff8;
    localparam logic [15:0] MTIME_HI_OFFSET = 16'hbffc;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } ar_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        id_t   id;
    } r_resp_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } aw_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_beat_t;

    typedef struct packed {
        resp_t resp;
        id_t   id;
    } b_resp_t;

    typedef union packed {
        logic [63:0] count;
        struct packed {
            data_t hi;
            data_t lo;
        } half;
    } mtime_u;

endpackage

// File: hw/mem_arbiter.sv
module mem_arbiter import soc_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  logic    fetch_ar_valid,
    input  ar_req_t fetch_ar,
    output logic    fetch_ar_ready,
    output logic    fetch_r_valid,
    output r_resp_t fetch_r,
    input  logic    fetch_r_ready,

    input  logic    data_ar_valid,
    input  ar_req_t data_ar,
    output logic    data_ar_ready,
    output logic    data_r_valid,
    output r_resp_t data_r,
    input  logic    data_r_ready,
    input  logic    data_aw_valid,
    input  aw_req_t data_aw,
    input  w_beat_t data_w,
    output logic    data_aw_ready,
    output logic    data_b_valid,
    output b_resp_t data_b,
    input  logic    data_b_ready,

    output logic    m_ar_valid,
    output ar_req_t m_ar,
    input  logic    m_ar_ready,
    input  logic    m_r_valid,
    input  r_resp_t m_r,
    output logic    m_r_ready,
    output logic    m_aw_valid,
    output aw_req_t m_aw,
    output w_beat_t m_w,
    input  logic    m_aw_ready,
    input  logic    m_b_valid,
    input  b_resp_t m_b,
    output logic    m_b_ready
);

    logic rd_busy;
    // 1 when the data port owns the read
    logic rd_owner;
    logic ar_wait;
    logic wr_busy;
    logic grant_data;
    logic ar_fire;
    logic r_fire;
    logic aw_fire;
    logic b_fire;

    // a stalled request keeps its grant so the payload stays stable
    assign grant_data = ar_wait ? rd_owner : data_ar_valid;

    assign m_ar_valid = !rd_busy && (fetch_ar_valid || data_ar_valid);
    assign m_ar.addr  = grant_data ? data_ar.addr : fetch_ar.addr;
    assign m_ar.id    = grant_data ? ID_DATA : ID_FETCH;

    assign data_ar_ready  = !rd_busy && grant_data && m_ar_ready;
    assign fetch_ar_ready = !rd_busy && !grant_data && m_ar_ready;

    assign fetch_r_valid = rd_busy && !rd_owner && m_r_valid;
    assign data_r_valid  = rd_busy && rd_owner && m_r_valid;
    assign fetch_r       = m_r;
    assign data_r        = m_r;
    assign m_r_ready     = rd_busy && (rd_owner ? data_r_ready : fetch_r_ready);

    // writes only come from the data port
    assign m_aw_valid    = data_aw_valid && !wr_busy;
    assign m_aw.addr     = data_aw.addr;
    assign m_aw.id       = ID_DATA;
    assign m_w           = data_w;
    assign data_aw_ready = !wr_busy && m_aw_ready;

    assign data_b_valid = wr_busy && m_b_valid;
    assign data_b       = m_b;
    assign m_b_ready    = wr_busy && data_b_ready;

    assign ar_fire = m_ar_valid && m_ar_ready;
    assign r_fire  = m_r_valid && m_r_ready;
    assign aw_fire = m_aw_valid && m_aw_ready;
    assign b_fire  = m_b_valid && m_b_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_busy  <= 1'b0;
            rd_owner <= 1'b0;
            ar_wait  <= 1'b0;
            wr_busy  <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_busy  <= 1'b1;
                rd_owner <= grant_data;
                ar_wait  <= 1'b0;
            end else if (m_ar_valid) begin
                rd_owner <= grant_data;
                ar_wait  <= 1'b1;
            end else if (r_fire) begin
                rd_busy <= 1'b0;
            end

            if (aw_fire) begin
                wr_busy <= 1'b1;
            end else if (b_fire) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // downstream only answers reads that were issued
    a_r_outstanding: assert property (@(posedge clock) disable iff (!reset)
        m_r_valid |-> rd_busy)
        else $error("read response with no read outstanding");

    a_r_owner_id: assert property (@(posedge clock) disable iff (!reset)
        rd_busy && m_r_valid |-> m_r.id == (rd_owner ? ID_DATA : ID_FETCH))
        else $error("read response id does not match the read owner");

endmodule

// File: hw/clint_soc_xbar.sv
module clint_soc_xbar import soc_pkg::*; #(
    parameter addr_t       CLINT_BASE = 32'h0200_0000,
    parameter int unsigned CLINT_SIZE = 32'h0001_0000
) (
    input  logic        clock,
    input  logic        reset,

    input  logic        m_ar_valid,
    input  ar_req_t     m_ar,
    output logic        m_ar_ready,
    output logic        m_r_valid,
    output r_resp_t     m_r,
    input  logic        m_r_ready,
    input  logic        m_aw_valid,
    input  aw_req_t     m_aw,
    input  w_beat_t     m_w,
    output logic        m_aw_ready,
    output logic        m_b_valid,
    output b_resp_t     m_b,
    input  logic        m_b_ready,

    output logic        c_ar_valid,
    output ar_req_t     c_ar,
    input  logic        c_ar_ready,
    input  logic        c_r_valid,
    input  r_resp_t     c_r,
    output logic        c_r_ready,
    output logic        c_aw_valid,
    output aw_req_t     c_aw,
    output w_beat_t     c_w,
    input  logic        c_aw_ready,
    input  logic        c_b_valid,
    input  b_resp_t     c_b,
    output logic        c_b_ready,

    input  logic        io_master_awready,
    output logic        io_master_awvalid,
    output id_t         io_master_awid,
    output addr_t       io_master_awaddr,
    output logic [7:0]  io_master_awlen,
    output logic [2:0]  io_master_awsize,
    output logic [1:0]  io_master_awburst,
    input  logic        io_master_wready,
    output logic        io_master_wvalid,
    output data_t       io_master_wdata,
    output strb_t       io_master_wstrb,
    output logic        io_master_wlast,
    output logic        io_master_bready,
    input  logic        io_master_bvalid,
    input  id_t         io_master_bid,
    input  resp_t       io_master_bresp,
    input  logic        io_master_arready,
    output logic        io_master_arvalid,
    output id_t         io_master_arid,
    output addr_t       io_master_araddr,
    output logic [7:0]  io_master_arlen,
    output logic [2:0]  io_master_arsize,
    output logic [1:0]  io_master_arburst,
    output logic        io_master_rready,
    input  logic        io_master_rvalid,
    input  id_t         io_master_rid,
    input  data_t       io_master_rdata,
    input  resp_t       io_master_rresp
);

    logic rd_busy;
    logic rd_to_clint;
    logic wr_busy;
    logic wr_to_clint;
    // soc side may take aw and w in different cycles
    logic aw_done;
    logic w_done;
    logic ar_is_clint;
    logic aw_is_clint;
    logic wr_open;
    logic soc_wr_ready;
    logic ar_fire;
    logic r_fire;
    logic aw_fire;
    logic b_fire;

    function automatic logic in_clint(input addr_t addr);
        return (addr >= CLINT_BASE) && (addr < CLINT_BASE + addr_t'(CLINT_SIZE));
    endfunction

    assign ar_is_clint = in_clint(m_ar.addr);
    assign aw_is_clint = in_clint(m_aw.addr);

    assign c_ar_valid        = m_ar_valid && !rd_busy && ar_is_clint;
    assign c_ar              = m_ar;
    assign io_master_arvalid = m_ar_valid && !rd_busy && !ar_is_clint;
    assign io_master_araddr  = m_ar.addr;
    assign io_master_arid    = m_ar.id;
    assign io_master_arlen   = AXI_LEN_SINGLE;
    assign io_master_arsize  = AXI_SIZE_WORD;
    assign io_master_arburst = AXI_BURST_INCR;
    assign m_ar_ready = !rd_busy && (ar_is_clint ? c_ar_ready : io_master_arready);

    assign m_r_valid = rd_busy && (rd_to_clint ? c_r_valid : io_master_rvalid);
    assign m_r       = rd_to_clint ? c_r : r_resp_t'{data: io_master_rdata,
                                                    resp: io_master_rresp, id: io_master_rid};
    assign c_r_ready       = rd_busy && rd_to_clint && m_r_ready;
    assign io_master_rready = rd_busy && !rd_to_clint && m_r_ready;

    assign wr_open    = m_aw_valid && !wr_busy;
    assign c_aw_valid = wr_open && aw_is_clint;
    assign c_aw       = m_aw;
    assign c_w        = m_w;

    assign io_master_awvalid = wr_open && !aw_is_clint && !aw_done;
    assign io_master_awaddr  = m_aw.addr;
    assign io_master_awid    = m_aw.id;
    assign io_master_awlen   = AXI_LEN_SINGLE;
    assign io_master_awsize  = AXI_SIZE_WORD;
    assign io_master_awburst = AXI_BURST_INCR;
    assign io_master_wvalid  = wr_open && !aw_is_clint && !w_done;
    assign io_master_wdata   = m_w.data;
    assign io_master_wstrb   = m_w.strb;
    assign io_master_wlast   = 1'b1;

    assign soc_wr_ready = (aw_done || io_master_awready) && (w_done || io_master_wready);
    assign m_aw_ready   = !wr_busy && (aw_is_clint ? c_aw_ready : soc_wr_ready);

    assign m_b_valid = wr_busy && (wr_to_clint ? c_b_valid : io_master_bvalid);
    assign m_b       = wr_to_clint ? c_b : b_resp_t'{resp: io_master_bresp, id: io_master_bid};
    assign c_b_ready        = wr_busy && wr_to_clint && m_b_ready;
    assign io_master_bready = wr_busy && !wr_to_clint && m_b_ready;

    assign ar_fire = m_ar_valid && m_ar_ready;
    assign r_fire  = m_r_valid && m_r_ready;
    assign aw_fire = m_aw_valid && m_aw_ready;
    assign b_fire  = m_b_valid && m_b_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_busy     <= 1'b0;
            rd_to_clint <= 1'b0;
            wr_busy     <= 1'b0;
            wr_to_clint <= 1'b0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_busy     <= 1'b1;
                rd_to_clint <= ar_is_clint;
            end else if (r_fire) begin
                rd_busy <= 1'b0;
            end

            if (aw_fire) begin
                wr_busy     <= 1'b1;
                wr_to_clint <= aw_is_clint;
                aw_done     <= 1'b0;
                w_done      <= 1'b0;
            end else begin
                if (io_master_awvalid && io_master_awready) begin
                    aw_done <= 1'b1;
                end
                if (io_master_wvalid && io_master_wready) begin
                    w_done <= 1'b1;
                end
                if (b_fire) begin
                    wr_busy <= 1'b0;
                end
            end
        end
    end

    a_resp_from_target: assert property (@(posedge clock) disable iff (!reset)
        (!c_r_valid || (rd_busy && rd_to_clint)) &&
        (!io_master_rvalid || (rd_busy && !rd_to_clint)) &&
        (!c_b_valid || (wr_busy && wr_to_clint)) &&
        (!io_master_bvalid || (wr_busy && !wr_to_clint)))
        else $error("response from unselected target");

endmodule

// File: hw/clint.sv
module clint import soc_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  logic    c_ar_valid,
    input  ar_req_t c_ar,
    output logic    c_ar_ready,
    output logic    c_r_valid,
    output r_resp_t c_r,
    input  logic    c_r_ready,
    input  logic    c_aw_valid,
    input  aw_req_t c_aw,
    input  w_beat_t c_w,
    output logic    c_aw_ready,
    output logic    c_b_valid,
    output b_resp_t c_b,
    input  logic    c_b_ready
);

    mtime_u mtime;
    logic   ar_fire;
    logic   aw_fire;

    assign c_ar_ready = !c_r_valid;
    assign c_aw_ready = !c_b_valid;
    assign ar_fire    = c_ar_valid && c_ar_ready;
    // write data is dropped since mtime is read only here
    assign aw_fire    = c_aw_valid && c_aw_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            mtime.count <= 64'd0;
            c_r_valid   <= 1'b0;
            c_b_valid   <= 1'b0;
        end else begin
            mtime.count <= mtime.count + 64'd1;
            if (ar_fire) begin
                c_r_valid <= 1'b1;
            end else if (c_r_ready) begin
                c_r_valid <= 1'b0;
            end
            if (aw_fire) begin
                c_b_valid <= 1'b1;
            end else if (c_b_ready) begin
                c_b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            c_r.id <= c_ar.id;
            case (c_ar.addr[15:0])
                MTIME_LO_OFFSET: begin
                    c_r.data <= mtime.half.lo;
                    c_r.resp <= RESP_OKAY;
                end
                MTIME_HI_OFFSET: begin
                    c_r.data <= mtime.half.hi;
                    c_r.resp <= RESP_OKAY;
                end
                default: begin
                    c_r.data <= '0;
                    c_r.resp <= RESP_SLVERR;
                end
            endcase
        end
        if (aw_fire) begin
            c_b.id   <= c_aw.id;
            c_b.resp <= RESP_SLVERR;
        end
    end

endmodule

// File: hw/soc_top.sv
module soc_top import soc_pkg::*; #(
    parameter addr_t       CLINT_BASE = 32'h0200_0000,
    parameter int unsigned CLINT_SIZE = 32'h0001_0000
) (
    input  logic        clock,
    input  logic        reset,

    input  logic        fetch_ar_valid,
    input  ar_req_t     fetch_ar,
    output logic        fetch_ar_ready,
    output logic        fetch_r_valid,
    output r_resp_t     fetch_r,
    input  logic        fetch_r_ready,

    input  logic        data_ar_valid,
    input  ar_req_t     data_ar,
    output logic        data_ar_ready,
    output logic        data_r_valid,
    output r_resp_t     data_r,
    input  logic        data_r_ready,
    input  logic        data_aw_valid,
    input  aw_req_t     data_aw,
    input  w_beat_t     data_w,
    output logic        data_aw_ready,
    output logic        data_b_valid,
    output b_resp_t     data_b,
    input  logic        data_b_ready,

    input  logic        io_master_awready,
    output logic        io_master_awvalid,
    output id_t         io_master_awid,
    output addr_t       io_master_awaddr,
    output logic [7:0]  io_master_awlen,
    output logic [2:0]  io_master_awsize,
    output logic [1:0]  io_master_awburst,
    input  logic        io_master_wready,
    output logic        io_master_wvalid,
    output data_t       io_master_wdata,
    output strb_t       io_master_wstrb,
    output logic        io_master_wlast,
    output logic        io_master_bready,
    input  logic        io_master_bvalid,
    input  id_t         io_master_bid,
    input  resp_t       io_master_bresp,
    input  logic        io_master_arready,
    output logic        io_master_arvalid,
    output id_t         io_master_arid,
    output addr_t       io_master_araddr,
    output logic [7:0]  io_master_arlen,
    output logic [2:0]  io_master_arsize,
    output logic [1:0]  io_master_arburst,
    output logic        io_master_rready,
    input  logic        io_master_rvalid,
    input  id_t         io_master_rid,
    input  data_t       io_master_rdata,
    input  resp_t       io_master_rresp
);

    // merged master
    logic    m_ar_valid;
    ar_req_t m_ar;
    logic    m_ar_ready;
    logic    m_r_valid;
    r_resp_t m_r;
    logic    m_r_ready;
    logic    m_aw_valid;
    aw_req_t m_aw;
    w_beat_t m_w;
    logic    m_aw_ready;
    logic    m_b_valid;
    b_resp_t m_b;
    logic    m_b_ready;

    // clint side
    logic    c_ar_valid;
    ar_req_t c_ar;
    logic    c_ar_ready;
    logic    c_r_valid;
    r_resp_t c_r;
    logic    c_r_ready;
    logic    c_aw_valid;
    aw_req_t c_aw;
    w_beat_t c_w;
    logic    c_aw_ready;
    logic    c_b_valid;
    b_resp_t c_b;
    logic    c_b_ready;

    mem_arbiter u_mem_arbiter (.*);

    clint_soc_xbar #(
        .CLINT_BASE(CLINT_BASE),
        .CLINT_SIZE(CLINT_SIZE)
    ) u_clint_soc_xbar (.*);

    clint u_clint (.*);

endmodule

// File: dv/soc_mem_model.sv
module soc_mem_model import soc_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  io_master_arvalid,
    input  id_t   io_master_arid,
    input  addr_t io_master_araddr,
    output logic  io_master_arready,
    output logic  io_master_rvalid,
    output id_t   io_master_rid,
    output data_t io_master_rdata,
    output resp_t io_master_rresp,
    input  logic  io_master_rready,
    input  logic  io_master_awvalid,
    input  id_t   io_master_awid,
    input  addr_t io_master_awaddr,
    output logic  io_master_awready,
    input  logic  io_master_wvalid,
    input  data_t io_master_wdata,
    input  strb_t io_master_wstrb,
    output logic  io_master_wready,
    output logic  io_master_bvalid,
    output id_t   io_master_bid,
    output resp_t io_master_bresp,
    input  logic  io_master_bready
);
    timeunit 1ns;
    timeprecision 100ps;

    data_t        mem [256];
    logic [255:0] written;
    // ready only on every other cycle
    logic         ready_phase;
    logic         r_pending;
    logic         r_delay;
    addr_t        r_addr;
    id_t          r_id;
    logic         aw_got;
    logic         w_got;
    addr_t        w_addr;
    id_t          w_id;
    data_t        w_data;
    strb_t        w_strb;

    function automatic data_t read_word(input addr_t addr);
        if (written[addr[9:2]]) begin
            return mem[addr[9:2]];
        end
        return addr ^ 32'ha5a5_5a5a;
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t strb);
        data_t result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = wd[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign io_master_arready = ready_phase && !r_pending && !io_master_rvalid;
    assign io_master_awready = ready_phase && !aw_got && !io_master_bvalid;
    assign io_master_wready  = ready_phase && !w_got && !io_master_bvalid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_phase      <= 1'b0;
            r_pending        <= 1'b0;
            r_delay          <= 1'b0;
            io_master_rvalid <= 1'b0;
            io_master_rid    <= '0;
            io_master_rdata  <= '0;
            io_master_rresp  <= RESP_OKAY;
            aw_got           <= 1'b0;
            w_got            <= 1'b0;
            io_master_bvalid <= 1'b0;
            io_master_bid    <= '0;
            io_master_bresp  <= RESP_OKAY;
            written          <= '0;
        end else begin
            ready_phase <= !ready_phase;
            // answer 2 cycles after the AR transfer
            if (io_master_arvalid && io_master_arready) begin
                r_pending <= 1'b1;
                r_delay   <= 1'b1;
                r_addr    <= io_master_araddr;
                r_id      <= io_master_arid;
            end else if (r_pending) begin
                if (r_delay) begin
                    r_delay <= 1'b0;
                end else begin
                    r_pending        <= 1'b0;
                    io_master_rvalid <= 1'b1;
                    io_master_rdata  <= read_word(r_addr);
                    io_master_rid    <= r_id;
                    io_master_rresp  <= RESP_OKAY;
                end
            end
            if (io_master_rvalid && io_master_rready) begin
                io_master_rvalid <= 1'b0;
            end

            if (io_master_awvalid && io_master_awready) begin
                aw_got <= 1'b1;
                w_addr <= io_master_awaddr;
                w_id   <= io_master_awid;
            end
            if (io_master_wvalid && io_master_wready) begin
                w_got  <= 1'b1;
                w_data <= io_master_wdata;
                w_strb <= io_master_wstrb;
            end
            if (aw_got && w_got) begin
                mem[w_addr[9:2]]     <= merge_bytes(read_word(w_addr), w_data, w_strb);
                written[w_addr[9:2]] <= 1'b1;
                io_master_bvalid     <= 1'b1;
                io_master_bid        <= w_id;
                io_master_bresp      <= RESP_OKAY;
                aw_got               <= 1'b0;
                w_got                <= 1'b0;
            end
            if (io_master_bvalid && io_master_bready) begin
                io_master_bvalid <= 1'b0;
            end
        end
    end

endmodule

// File: dv/tb_soc_top.sv
module tb_soc_top import soc_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t       CLINT_BASE  = 32'h0200_0000;
    localparam int unsigned CLINT_SIZE  = 32'h0001_0000;
    localparam int          CYCLE_LIMIT = 2000;
    localparam data_t       FILL_MASK   = 32'ha5a5_5a5a;

    logic       clock;
    logic       reset;
    logic       fetch_ar_valid;
    ar_req_t    fetch_ar;
    logic       fetch_ar_ready;
    logic       fetch_r_valid;
    r_resp_t    fetch_r;
    logic       fetch_r_ready;
    logic       data_ar_valid;
    ar_req_t    data_ar;
    logic       data_ar_ready;
    logic       data_r_valid;
    r_resp_t    data_r;
    logic       data_r_ready;
    logic       data_aw_valid;
    aw_req_t    data_aw;
    w_beat_t    data_w;
    logic       data_aw_ready;
    logic       data_b_valid;
    b_resp_t    data_b;
    logic       data_b_ready;

    logic       io_master_awready;
    logic       io_master_awvalid;
    id_t        io_master_awid;
    addr_t      io_master_awaddr;
    logic [7:0] io_master_awlen;
    logic [2:0] io_master_awsize;
    logic [1:0] io_master_awburst;
    logic       io_master_wready;
    logic       io_master_wvalid;
    data_t      io_master_wdata;
    strb_t      io_master_wstrb;
    logic       io_master_wlast;
    logic       io_master_bready;
    logic       io_master_bvalid;
    id_t        io_master_bid;
    resp_t      io_master_bresp;
    logic       io_master_arready;
    logic       io_master_arvalid;
    id_t        io_master_arid;
    addr_t      io_master_araddr;
    logic [7:0] io_master_arlen;
    logic [2:0] io_master_arsize;
    logic [1:0] io_master_arburst;
    logic       io_master_rready;
    logic       io_master_rvalid;
    id_t        io_master_rid;
    data_t      io_master_rdata;
    resp_t      io_master_rresp;

    integer seed;
    int     cycles = 0;
    int     mismatches = 0;
    int     failures = 0;
    string  test_name;
    logic   check_reset;
    logic   check_arid;
    logic   clint_only;
    logic   lo_check;
    id_t    exp_arid;
    data_t  exp_fetch_data;
    data_t  exp_data_data;
    resp_t  exp_data_resp;
    resp_t  exp_b_resp;
    data_t  lo_min;
    data_t  last_rdata;
    addr_t  addr_f;
    addr_t  addr_d;
    data_t  wdata;

    soc_top #(
        .CLINT_BASE(CLINT_BASE),
        .CLINT_SIZE(CLINT_SIZE)
    ) soc_top_inst (.*);

    soc_mem_model mem_model (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR in %s: %s", test_name, what);
        failures++;
    endtask

    a_reset_quiet: assert property (@(posedge clock) check_reset |->
        !(io_master_arvalid || io_master_awvalid || io_master_wvalid ||
          fetch_r_valid || data_r_valid || data_b_valid))
        else report_failure("request or response valid during reset");

    a_ar_fixed: assert property (@(posedge clock) disable iff (!reset) io_master_arvalid |->
        {io_master_arlen, io_master_arsize, io_master_arburst} == {8'd0, 3'd2, 2'b01})
        else report_mismatch("ar len/size/burst", 64'({8'd0, 3'd2, 2'b01}),
            64'($sampled({io_master_arlen, io_master_arsize, io_master_arburst})));

    a_aw_fixed: assert property (@(posedge clock) disable iff (!reset) io_master_awvalid |->
        {io_master_awlen, io_master_awsize, io_master_awburst} == {8'd0, 3'd2, 2'b01})
        else report_mismatch("aw len/size/burst", 64'({8'd0, 3'd2, 2'b01}),
            64'($sampled({io_master_awlen, io_master_awsize, io_master_awburst})));

    // single-beat writes
    a_wlast: assert property (@(posedge clock) disable iff (!reset)
        io_master_wvalid |-> io_master_wlast)
        else report_mismatch("wlast", 64'(1'b1), 64'($sampled(io_master_wlast)));

    a_arid: assert property (@(posedge clock) disable iff (!reset)
        io_master_arvalid && check_arid |-> io_master_arid == exp_arid)
        else report_mismatch("arid", 64'(exp_arid), 64'($sampled(io_master_arid)));

    a_awid: assert property (@(posedge clock) disable iff (!reset)
        io_master_awvalid |-> io_master_awid == ID_DATA)
        else report_mismatch("awid", 64'(ID_DATA), 64'($sampled(io_master_awid)));

    a_fetch_r: assert property (@(posedge clock) disable iff (!reset)
        fetch_r_valid && fetch_r_ready |->
        fetch_r.data == exp_fetch_data && fetch_r.resp == RESP_OKAY)
        else report_mismatch("fetch data/resp", 64'({exp_fetch_data, RESP_OKAY}),
            64'($sampled({fetch_r.data, fetch_r.resp})));

    a_data_r: assert property (@(posedge clock) disable iff (!reset)
        data_r_valid && data_r_ready && !lo_check |->
        data_r.data == exp_data_data && data_r.resp == exp_data_resp)
        else report_mismatch("data data/resp", 64'({exp_data_data, exp_data_resp}),
            64'($sampled({data_r.data, data_r.resp})));

    // mtime low half only has a lower bound
    a_mtime_lo: assert property (@(posedge clock) disable iff (!reset)
        data_r_valid && data_r_ready && lo_check |->
        data_r.data >= lo_min && data_r.resp == RESP_OKAY)
        else report_mismatch("mtime low at least", 64'(lo_min), 64'($sampled(data_r.data)));

    a_data_b: assert property (@(posedge clock) disable iff (!reset)
        data_b_valid && data_b_ready |-> data_b.resp == exp_b_resp)
        else report_mismatch("bresp", 64'(exp_b_resp), 64'($sampled(data_b.resp)));

    a_clint_local: assert property (@(posedge clock) disable iff (!reset)
        clint_only |-> !io_master_arvalid && !io_master_awvalid)
        else report_failure("io_master request seen during a clint access");

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic addr_t random_soc_addr();
        return 32'h8000_0000 | (addr_t'($random(seed)) & 32'h0000_03fc);
    endfunction

    // all handshake tasks start and end on a falling edge
    task automatic read_fetch(input addr_t addr);
        @(negedge clock);
        fetch_ar_valid = 1'b1;
        fetch_ar.addr = addr;
        fetch_ar.id = '0;
        #1;
        while (!fetch_ar_ready) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        fetch_ar_valid = 1'b0;
        #1;
        while (!fetch_r_valid) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
    endtask

    task automatic read_data(input addr_t addr);
        @(negedge clock);
        data_ar_valid = 1'b1;
        data_ar.addr = addr;
        data_ar.id = '0;
        #1;
        while (!data_ar_ready) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        data_ar_valid = 1'b0;
        #1;
        while (!data_r_valid) begin
            @(negedge clock);
            #1;
        end
        last_rdata = data_r.data;
        @(negedge clock);
    endtask

    task automatic write_data(input addr_t addr, input data_t value, input strb_t strb);
        @(negedge clock);
        data_aw_valid = 1'b1;
        data_aw.addr = addr;
        data_aw.id = '0;
        data_w.data = value;
        data_w.strb = strb;
        #1;
        while (!data_aw_ready) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        data_aw_valid = 1'b0;
        #1;
        while (!data_b_valid) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
    endtask

    task automatic release_arid_after_first_ar();
        @(negedge clock);
        #1;
        while (!(io_master_arvalid && io_master_arready)) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        check_arid = 1'b0;
    endtask

    initial begin
        seed = 23;
        test_name = "reset";
        reset = 1'b0;
        check_reset = 1'b0;
        check_arid = 1'b0;
        clint_only = 1'b0;
        lo_check = 1'b0;
        exp_arid = '0;
        exp_fetch_data = '0;
        exp_data_data = '0;
        exp_data_resp = RESP_OKAY;
        exp_b_resp = RESP_OKAY;
        lo_min = '0;
        fetch_ar_valid = 1'b0;
        fetch_ar = '0;
        fetch_r_ready = 1'b1;
        data_ar_valid = 1'b0;
        data_ar = '0;
        data_r_ready = 1'b1;
        data_aw_valid = 1'b0;
        data_aw = '0;
        data_w = '0;
        data_b_ready = 1'b1;

        // four rising edges with reset low
        @(posedge clock);
        @(negedge clock);
        check_reset = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        check_reset = 1'b0;

        test_name = "fetch_soc";
        addr_f = random_soc_addr();
        exp_fetch_data = addr_f ^ FILL_MASK;
        exp_arid = ID_FETCH;
        check_arid = 1'b1;
        read_fetch(addr_f);
        check_arid = 1'b0;

        // writes stay in the lower half of the model window
        test_name = "data_write_read";
        addr_d = random_soc_addr() & ~32'h0000_0200;
        wdata = $random(seed);
        exp_b_resp = RESP_OKAY;
        write_data(addr_d, wdata, 4'hf);
        exp_data_data = wdata;
        exp_data_resp = RESP_OKAY;
        exp_arid = ID_DATA;
        check_arid = 1'b1;
        read_data(addr_d);
        check_arid = 1'b0;

        test_name = "priority";
        addr_f = random_soc_addr() | 32'h0000_0200;
        addr_d = addr_f ^ 32'h0000_0100;
        exp_fetch_data = addr_f ^ FILL_MASK;
        exp_data_data = addr_d ^ FILL_MASK;
        exp_arid = ID_DATA;
        check_arid = 1'b1;
        fork
            read_fetch(addr_f);
            read_data(addr_d);
            release_arid_after_first_ar();
        join

        test_name = "clint_mtime";
        clint_only = 1'b1;
        lo_check = 1'b1;
        lo_min = 32'd1;
        read_data(CLINT_BASE + {16'h0000, MTIME_LO_OFFSET});
        lo_min = last_rdata + 32'd10;
        repeat (12) @(negedge clock);
        read_data(CLINT_BASE + {16'h0000, MTIME_LO_OFFSET});
        lo_check = 1'b0;
        exp_data_data = '0;
        exp_data_resp = RESP_OKAY;
        read_data(CLINT_BASE + {16'h0000, MTIME_HI_OFFSET});

        test_name = "clint_errors";
        exp_b_resp = RESP_SLVERR;
        write_data(CLINT_BASE + 32'h0000_4000, $random(seed), 4'hf);
        exp_data_data = '0;
        exp_data_resp = RESP_SLVERR;
        read_data(CLINT_BASE + 32'h0000_0100);
        clint_only = 1'b0;

        repeat (2) @(negedge clock);
        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
hw/soc_pkg.sv
hw/mem_arbiter.sv
hw/clint_soc_xbar.sv
hw/clint.sv
hw/soc_top.sv
dv/soc_mem_model.sv
dv/tb_soc_top.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert -j 0 --top-module tb_soc_top -f files.f \
    && ./obj_dir/Vtb_soc_top | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
